/* Bender.yml */
package:
  name: snake_game

sources:
  - common/snake_pkg.sv
  - verilog/direction_latch.sv
  - verilog/apple_lfsr.sv
  - snake_body/body_fifo.sv
  - snake_body/occupancy_map.sv
  - verilog/game_sequencer.sv
  - verilog/snake_game.sv
  - target: simulation
    files:
      - verification/tb_snake_game.sv

/* common/snake_pkg.sv */
package snake_pkg;

    // one board cell, y in [7:4] and x in [3:0]
    typedef logic [7:0] cell_t;
    typedef logic [3:0] coord_t;
    // rgb, one bit per channel
    typedef logic [2:0] colour_t;
    typedef logic [7:0] score_t;
    // turn delay in clock cycles
    typedef logic [26:0] stall_t;

    typedef enum logic [1:0] {
        dir_left,
        dir_right,
        dir_up,
        dir_down
    } dir_t;

    // free cell
    localparam colour_t colour_black = 3'b000;
    localparam colour_t colour_red   = 3'b100;
    localparam colour_t colour_green = 3'b010;
    localparam colour_t colour_white = 3'b111;

    // snake starts at column 7 heading down, apple mid board
    localparam cell_t start_head  = 8'h17;
    localparam cell_t start_tail  = 8'h07;
    localparam cell_t start_apple = 8'h88;

    // odd step, so a search visits every cell once before repeating
    localparam logic [7:0] apple_skip = 8'd7;

endpackage

/* sim.f */
common/snake_pkg.sv
verilog/direction_latch.sv
verilog/apple_lfsr.sv
snake_body/body_fifo.sv
snake_body/occupancy_map.sv
verilog/game_sequencer.sv
verilog/snake_game.sv
verification/tb_snake_game.sv

/* snake_body/body_fifo.sv */
`timescale 1ns/100ps

module body_fifo import snake_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,
    input  logic  push,
    input  logic  pop,
    input  logic  rd_req,
    input  cell_t push_cell,
    output cell_t tail_next
);

    // body cells in order, oldest at rd_ptr, newest just below wr_ptr
    cell_t      mem [256];
    logic [7:0] wr_ptr;
    logic [7:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (load) begin
            // start head is the only entry
            wr_ptr <= 8'd1;
            rd_ptr <= 8'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 8'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 8'd1;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (load) begin
            mem[0] <= start_head;
        end else if (push) begin
            mem[wr_ptr] <= push_cell;
        end
        if (rd_req) begin
            tail_next <= mem[rd_ptr];
        end
    end

    // a new game never overlaps a head write
    assert property (@(posedge clk) disable iff (!rst_n) !(push && load));

endmodule

/* snake_body/occupancy_map.sv */
`timescale 1ns/100ps

module occupancy_map import snake_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  set,
    input  logic  clr,
    input  logic  clear_all,
    input  cell_t set_cell,
    input  cell_t clr_cell,
    input  cell_t probe_head,
    input  cell_t probe_apple,
    output logic  body_hit,
    output logic  apple_hit
);

    // one bit per cell, the plotted last tail is kept out
    logic [255:0] map;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_all) begin
            map <= '0;
        end else begin
            if (set) begin
                map[set_cell] <= 1'b1;
            end
            if (clr) begin
                map[clr_cell] <= 1'b0;
            end
        end
    end

    // zero-cycle lookups
    assign body_hit  = map[probe_head];
    assign apple_hit = map[probe_apple];

endmodule

/* verification/tb_snake_game.sv */
`timescale 1ns/100ps

module tb_snake_game import snake_pkg::*; ();

    localparam stall_t tb_stall_base = 27'd20;
    localparam stall_t tb_stall_decr = 27'd2;
    localparam int     reset_cycles  = 16;
    // worst back-pressure run per plot with margin
    localparam int     plot_slack    = 40;
    // 2 + 2 + 4 + 7 moving turns and the fatal one
    localparam int     num_turns     = 16;
    localparam int     death_cycles  = 4 * (tb_stall_base + 1);
    localparam int     max_cycles    = reset_cycles + 200 + death_cycles
                                       + num_turns * (tb_stall_base + 1 + 4 * plot_slack);

    // button masks in {left, right, up, down} order
    localparam logic [3:0] btn_left  = 4'b1000;
    localparam logic [3:0] btn_right = 4'b0100;
    localparam logic [3:0] btn_up    = 4'b0010;
    localparam logic [3:0] btn_down  = 4'b0001;

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    in_left;
    logic    in_right;
    logic    in_up;
    logic    in_down;
    logic    waitrequest;
    logic    game_plot_waitrequest = 1'b1;
    logic    game_plot;
    coord_t  game_x;
    coord_t  game_y;
    colour_t game_colour;
    score_t  score;

    // plotter model state
    logic [31:0] bp_lfsr = 32'hf1f2;
    colour_t     board [256];
    cell_t       plot_cells [$];
    colour_t     plot_colours [$];
    colour_t     plot_prev [$];
    logic        held_valid = 1'b0;
    cell_t       held_cell;
    colour_t     held_colour;

    // reference model of the game
    cell_t  snake_q [$];
    cell_t  apple_cell;
    score_t exp_score;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int cycle_count = 0;

    snake_game #(
        .stall_base(tb_stall_base),
        .stall_decr(tb_stall_decr)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .in_left(in_left),
        .in_right(in_right),
        .in_up(in_up),
        .in_down(in_down),
        .waitrequest(waitrequest),
        .game_plot_waitrequest(game_plot_waitrequest),
        .game_plot(game_plot),
        .game_x(game_x),
        .game_y(game_y),
        .game_colour(game_colour),
        .score(score)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // compare helpers
    ////////////////////////////////////////
    task automatic check_cell(input string name, input cell_t got, input cell_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // one galois step where bit 0 is the bit taken
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    ////////////////////////////////////////
    // plotter model
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            // a request stalled last cycle must come back unchanged
            if (held_valid) begin
                check_bit("game_plot", game_plot, 1'b1);
                check_cell("{game_y, game_x}", {game_y, game_x}, held_cell);
                check_colour("game_colour", game_colour, held_colour);
            end
            held_valid  = game_plot && game_plot_waitrequest;
            held_cell   = {game_y, game_x};
            held_colour = game_colour;
            // on acceptance record the plot and paint the shadow board
            if (game_plot && !game_plot_waitrequest) begin
                plot_cells.push_back({game_y, game_x});
                plot_colours.push_back(game_colour);
                plot_prev.push_back(board[{game_y, game_x}]);
                board[{game_y, game_x}] = game_colour;
            end
        end
        bp_lfsr = galois_step(bp_lfsr);
        game_plot_waitrequest <= bp_lfsr[0];
    end

    ////////////////////////////////////////
    // stimulus and model helpers
    ////////////////////////////////////////
    task automatic press_buttons(input logic [3:0] buttons, input int cycles);
        @(posedge clk);
        {in_left, in_right, in_up, in_down} <= buttons;
        repeat (cycles) @(posedge clk);
        {in_left, in_right, in_up, in_down} <= 4'b0000;
    endtask

    // next cell one step from c with y in the upper nibble
    function automatic cell_t step_cell(input cell_t c, input dir_t d);
        coord_t x;
        coord_t y;
        x = c[3:0];
        y = c[7:4];
        case (d)
            dir_left:  x = x - 4'd1;
            dir_right: x = x + 4'd1;
            dir_up:    y = y - 4'd1;
            default:   y = y + 4'd1;
        endcase
        return {y, x};
    endfunction

    // true when c is any cell of the shadow snake, tail included
    function automatic logic on_snake(input cell_t c);
        foreach (snake_q[i]) begin
            if (snake_q[i] == c) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // next accepted plot must be this cell and colour
    task automatic expect_plot(input cell_t exp_cell, input colour_t exp_colour);
        while (plot_cells.size() == 0) @(negedge clk);
        check_cell("plot cell", plot_cells.pop_front(), exp_cell);
        check_colour("plot colour", plot_colours.pop_front(), exp_colour);
        void'(plot_prev.pop_front());
    endtask

    // new apple lands on a free cell and never on the snake
    task automatic expect_apple();
        cell_t   c;
        colour_t prev;
        while (plot_cells.size() == 0) @(negedge clk);
        c    = plot_cells.pop_front();
        prev = plot_prev.pop_front();
        check_colour("plot colour", plot_colours.pop_front(), colour_red);
        check_colour("board colour under apple", prev, colour_black);
        check_count++;
        if (on_snake(c)) begin
            error_count++;
            $display("apple placed on the snake at cell %h", c);
        end
        apple_cell = c;
        check_score("score", score, exp_score);
    endtask

    // one move of the snake and the plots it should cause
    task automatic do_turn(input dir_t d);
        cell_t old_head;
        cell_t old_tail;
        cell_t new_head;
        old_head = snake_q[$];
        old_tail = snake_q[0];
        new_head = step_cell(old_head, d);
        expect_plot(new_head, colour_green);
        expect_plot(old_head, colour_white);
        snake_q.push_back(new_head);
        if (new_head == apple_cell) begin
            // growth keeps the tail in place
            exp_score++;
            expect_apple();
        end else begin
            expect_plot(old_tail, colour_black);
            void'(snake_q.pop_front());
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_start();
        int e;
        e = error_count;
        check_bit("waitrequest", waitrequest, 1'b0);
        check_bit("game_plot", game_plot, 1'b0);
        check_score("score", score, 8'd0);
        @(posedge clk);
        start   <= 1'b1;
        in_down <= 1'b1;
        // hold length seeds the apple lfsr
        repeat (5) @(posedge clk);
        start   <= 1'b0;
        in_down <= 1'b0;
        @(negedge clk);
        expect_plot(start_apple, colour_red);
        expect_plot(start_head, colour_green);
        expect_plot(start_tail, colour_white);
        snake_q    = '{start_tail, start_head};
        apple_cell = start_apple;
        exp_score  = '0;
        check_bit("waitrequest", waitrequest, 1'b1);
        report_test("start", e);
    endtask

    task automatic test_idle_moves();
        int e;
        e = error_count;
        do_turn(dir_down);
        do_turn(dir_down);
        report_test("idle moves", e);
    endtask

    task automatic test_steering();
        int e;
        e = error_count;
        // reversal is refused
        press_buttons(btn_up, 3);
        do_turn(dir_down);
        press_buttons(btn_right, 3);
        do_turn(dir_right);
        report_test("steering", e);
    endtask

    task automatic test_apple();
        int e;
        e = error_count;
        // down column 8 to the apple at (8,8)
        press_buttons(btn_down, 3);
        repeat (4) do_turn(dir_down);
        check_score("score", score, 8'd1);
        report_test("apple", e);
    endtask

    task automatic test_wall();
        int e;
        e = error_count;
        press_buttons(btn_right, 3);
        repeat (7) do_turn(dir_right);
        // next move leaves the board
        repeat (death_cycles) @(posedge clk);
        @(negedge clk);
        check_count++;
        if (plot_cells.size() != 0) begin
            error_count++;
            $display("plot accepted after the snake hit the wall");
        end
        check_bit("game_plot", game_plot, 1'b0);
        check_bit("waitrequest", waitrequest, 1'b1);
        press_buttons(btn_left, 3);
        while (waitrequest) @(negedge clk);
        // board stays as it was on the way back to idle
        check_count++;
        if (plot_cells.size() != 0) begin
            error_count++;
            $display("plot accepted while returning to idle");
        end
        check_score("score", score, exp_score);
        report_test("wall", e);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        in_left  = 1'b0;
        in_right = 1'b0;
        in_up    = 1'b0;
        in_down  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            board[i] = colour_black;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_start();
        test_idle_moves();
        test_steering();
        test_apple();
        test_wall();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", max_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verilog/apple_lfsr.sv */
`timescale 1ns/100ps

module apple_lfsr import snake_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  seeding,
    input  logic  any_button,
    input  logic  eaten,
    output cell_t rand_cell
);

    logic        seed_active;
    logic [10:0] seed_count;
    // 11 bits so 8-bit outputs repeat only after 2^11 - 1 steps
    logic [10:0] lfsr;
    logic [3:0]  shift_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seed_active <= 1'b0;
            seed_count  <= '0;
            lfsr        <= '0;
            shift_count <= 4'd8;
        end else begin
            ////////////////////////////////////////
            // seed from the start press length
            ////////////////////////////////////////
            if (seeding) begin
                seed_active <= 1'b1;
                seed_count  <= '0;
            end else if (seed_active) begin
                if (any_button) begin
                    // wraps freely, only the low bits matter
                    seed_count <= seed_count + 11'd1;
                end else begin
                    seed_active <= 1'b0;
                    // all ones is the xnor lock-up state
                    lfsr <= (seed_count == 11'h7ff) ? 11'd0 : seed_count;
                end
            end

            ////////////////////////////////////////
            // 8 shifts per apple
            ////////////////////////////////////////
            if (eaten) begin
                shift_count <= 4'd0;
            end else if (shift_count < 4'd8) begin
                // taps 11 and 9, maximal length
                lfsr        <= {lfsr[9:0], ~(lfsr[10] ^ lfsr[8])};
                shift_count <= shift_count + 4'd1;
            end
        end
    end

    assign rand_cell = lfsr[7:0];

    // seed mapping and xnor feedback keep the lfsr out of lock-up
    assert property (@(posedge clk) disable iff (!rst_n) lfsr != 11'h7ff);

endmodule

/* verilog/direction_latch.sv */
`timescale 1ns/100ps

module direction_latch import snake_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_left,
    input  logic in_right,
    input  logic in_up,
    input  logic in_down,
    input  dir_t current,
    input  logic force_down,
    output dir_t next_dir
);

    // direction that would undo a move
    function automatic dir_t opposite(input dir_t d);
        return dir_t'({d[1], ~d[0]});
    endfunction

    // refuse a reversal of the sampled direction and of the pending one,
    // a press on the sampling edge would otherwise slip a reversal through
    function automatic logic legal(input dir_t d, input dir_t cur, input dir_t pend);
        return (d != opposite(cur)) && (d != opposite(pend));
    endfunction

    // priority down, left, right, up
    always_ff @(posedge clk) begin
        if (!rst_n || force_down) begin
            next_dir <= dir_down;
        end else if (in_down && legal(dir_down, current, next_dir)) begin
            next_dir <= dir_down;
        end else if (in_left && legal(dir_left, current, next_dir)) begin
            next_dir <= dir_left;
        end else if (in_right && legal(dir_right, current, next_dir)) begin
            next_dir <= dir_right;
        end else if (in_up && legal(dir_up, current, next_dir)) begin
            next_dir <= dir_up;
        end
    end

    // once play runs, the next sampled direction never reverses the snake
    assert property (@(posedge clk) disable iff (!rst_n)
        !force_down |-> next_dir != opposite(current));

endmodule

/* verilog/game_sequencer.sv */
`timescale 1ns/100ps

module game_sequencer import snake_pkg::*; #(
    parameter stall_t stall_base = 27'd12_500_000,
    parameter stall_t stall_decr = 27'd39_000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    in_left,
    input  logic    in_right,
    input  logic    in_up,
    input  logic    in_down,
    input  logic    game_plot_waitrequest,
    input  dir_t    next_dir,
    input  cell_t   tail_next,
    input  logic    body_hit,
    input  logic    apple_hit,
    input  cell_t   rand_cell,
    output logic    waitrequest,
    output logic    game_plot,
    output coord_t  game_x,
    output coord_t  game_y,
    output colour_t game_colour,
    output score_t  score,
    output dir_t    current,
    output logic    force_down,
    output logic    body_load,
    output logic    body_push,
    output logic    body_pop,
    output logic    body_rd_req,
    output cell_t   push_cell,
    output logic    map_set,
    output cell_t   set_cell,
    output logic    map_clr,
    output cell_t   clr_cell,
    output logic    map_clear,
    output cell_t   probe_head,
    output cell_t   probe_apple,
    output logic    seeding,
    output logic    button_held,
    output logic    eaten
);

    typedef enum logic [4:0] {
        st_idle, st_init_apple, st_init_head, st_init_tail, st_release_wait,
        st_stall, st_collision, st_head, st_head_plot, st_neck, st_neck_plot,
        st_tail, st_tail_plot, st_apple_search, st_apple_plot,
        st_death_wait, st_release
    } state_t;

    state_t state;
    stall_t count;
    stall_t stall_num;
    cell_t  head;
    cell_t  neck;
    cell_t  last_tail;
    cell_t  apple;
    // apple search position
    cell_t  candidate;
    cell_t  new_head;
    logic   out_of_bounds;
    logic   any_button;
    logic   accepted;

    assign any_button = in_left || in_right || in_up || in_down;
    assign accepted   = game_plot && !game_plot_waitrequest;

    // next head and wall check from the sampled direction
    always_comb begin
        new_head      = head;
        out_of_bounds = 1'b0;
        case (current)
            dir_left: begin
                new_head      = head - 8'h01;
                out_of_bounds = (head[3:0] == 4'h0);
            end
            dir_right: begin
                new_head      = head + 8'h01;
                out_of_bounds = (head[3:0] == 4'hf);
            end
            dir_up: begin
                new_head      = head - 8'h10;
                out_of_bounds = (head[7:4] == 4'h0);
            end
            default: begin
                new_head      = head + 8'h10;
                out_of_bounds = (head[7:4] == 4'hf);
            end
        endcase
    end

    // present one plot request
    task automatic request_plot(input cell_t c, input colour_t colour);
        game_plot   <= 1'b1;
        game_x      <= c[3:0];
        game_y      <= c[7:4];
        game_colour <= colour;
    endtask

    ////////////////////////////////////////
    // turn fsm
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            stall_num <= stall_base;
            count     <= '0;
            current   <= dir_down;
            head      <= start_head;
            score     <= '0;
            game_plot <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start && any_button) begin
                        state     <= st_init_apple;
                        stall_num <= stall_base;
                        current   <= dir_down;
                        head      <= start_head;
                        last_tail <= start_tail;
                        apple     <= start_apple;
                        score     <= '0;
                        request_plot(start_apple, colour_red);
                    end
                end
                st_init_apple: begin
                    if (accepted) begin
                        state <= st_init_head;
                        request_plot(head, colour_green);
                    end
                end
                st_init_head: begin
                    if (accepted) begin
                        state <= st_init_tail;
                        request_plot(last_tail, colour_white);
                    end
                end
                st_init_tail: begin
                    if (accepted) begin
                        game_plot <= 1'b0;
                        state     <= st_release_wait;
                    end
                end
                // start button must not steer the first move
                st_release_wait: begin
                    if (!any_button) begin
                        state <= st_stall;
                        count <= '0;
                    end
                end
                st_stall: begin
                    count <= count + 27'd1;
                    if (count >= stall_num) begin
                        state   <= st_collision;
                        // one direction sample per turn
                        current <= next_dir;
                    end
                end
                st_collision: begin
                    if (out_of_bounds || body_hit) begin
                        state <= st_death_wait;
                    end else begin
                        state <= st_head;
                        head  <= new_head;
                        neck  <= head;
                    end
                end
                st_head: begin
                    state <= st_head_plot;
                    request_plot(head, colour_green);
                end
                st_head_plot: begin
                    if (accepted) begin
                        game_plot <= 1'b0;
                        state     <= st_neck;
                    end
                end
                // old head turns to body colour
                st_neck: begin
                    state <= st_neck_plot;
                    request_plot(neck, colour_white);
                end
                st_neck_plot: begin
                    if (accepted) begin
                        game_plot <= 1'b0;
                        if (head == apple) begin
                            // tail stays, snake grows by one
                            state     <= st_apple_search;
                            candidate <= rand_cell;
                            score     <= score + 8'd1;
                            stall_num <= stall_num - stall_decr;
                        end else begin
                            state <= st_tail;
                        end
                    end
                end
                // cell above the old tail becomes the new last tail
                st_tail: begin
                    last_tail <= tail_next;
                    if (last_tail != head) begin
                        state <= st_tail_plot;
                        request_plot(last_tail, colour_black);
                    end else begin
                        // head took over the old tail cell
                        state <= st_stall;
                        count <= '0;
                    end
                end
                st_tail_plot, st_apple_plot: begin
                    if (accepted) begin
                        game_plot <= 1'b0;
                        state     <= st_stall;
                        count     <= '0;
                    end
                end
                // last tail is plotted but not in the map, check it too
                st_apple_search: begin
                    if (apple_hit || candidate == last_tail) begin
                        candidate <= candidate + apple_skip;
                    end else begin
                        state <= st_apple_plot;
                        apple <= candidate;
                        request_plot(candidate, colour_red);
                    end
                end
                // board stays as it was until a press and release
                st_death_wait: begin
                    if (any_button) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    if (!any_button) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // strobes to the datapath blocks
    ////////////////////////////////////////
    assign waitrequest = (state != st_idle);
    assign force_down  = state inside {st_idle, st_init_apple, st_init_head,
                                       st_init_tail, st_release_wait};
    assign body_load   = (state == st_idle) && start && any_button;
    assign body_push   = (state == st_head);
    assign push_cell   = head;
    // tail read issued early, valid from st_head on
    assign body_rd_req = (state == st_collision);
    assign body_pop    = (state == st_tail);
    assign map_set     = body_load || body_push;
    assign set_cell    = body_load ? start_head : head;
    assign map_clr     = body_pop;
    assign clr_cell    = tail_next;
    assign map_clear   = (state == st_release) && !any_button;
    assign probe_head  = new_head;
    assign probe_apple = candidate;
    assign seeding     = (state == st_idle) && start;
    assign button_held = any_button;
    // lfsr steps once the new apple is on screen
    assign eaten       = (state == st_apple_plot) && accepted;

    // requests held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        game_plot && game_plot_waitrequest |=> game_plot);
    assert property (@(posedge clk) disable iff (!rst_n)
        game_plot && game_plot_waitrequest |=> $stable({game_x, game_y, game_colour}));

endmodule

/* verilog/snake_game.sv */
`timescale 1ns/100ps

module snake_game import snake_pkg::*; #(
    parameter stall_t stall_base = 27'd12_500_000,
    parameter stall_t stall_decr = 27'd39_000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    in_left,
    input  logic    in_right,
    input  logic    in_up,
    input  logic    in_down,
    output logic    waitrequest,
    input  logic    game_plot_waitrequest,
    output logic    game_plot,
    output coord_t  game_x,
    output coord_t  game_y,
    output colour_t game_colour,
    output score_t  score
);

    // direction handoff
    dir_t  next_dir;
    dir_t  current;
    logic  force_down;
    // body fifo
    logic  body_load;
    logic  body_push;
    logic  body_pop;
    logic  body_rd_req;
    cell_t push_cell;
    cell_t tail_next;
    // occupancy map
    logic  map_set;
    logic  map_clr;
    logic  map_clear;
    cell_t set_cell;
    cell_t clr_cell;
    cell_t probe_head;
    cell_t probe_apple;
    logic  body_hit;
    logic  apple_hit;
    // apple placement
    logic  seeding;
    logic  button_held;
    logic  eaten;
    cell_t rand_cell;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    game_sequencer #(
        .stall_base(stall_base),
        .stall_decr(stall_decr)
    ) u_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .in_left(in_left),
        .in_right(in_right),
        .in_up(in_up),
        .in_down(in_down),
        .game_plot_waitrequest(game_plot_waitrequest),
        .next_dir(next_dir),
        .tail_next(tail_next),
        .body_hit(body_hit),
        .apple_hit(apple_hit),
        .rand_cell(rand_cell),
        .waitrequest(waitrequest),
        .game_plot(game_plot),
        .game_x(game_x),
        .game_y(game_y),
        .game_colour(game_colour),
        .score(score),
        .current(current),
        .force_down(force_down),
        .body_load(body_load),
        .body_push(body_push),
        .body_pop(body_pop),
        .body_rd_req(body_rd_req),
        .push_cell(push_cell),
        .map_set(map_set),
        .set_cell(set_cell),
        .map_clr(map_clr),
        .clr_cell(clr_cell),
        .map_clear(map_clear),
        .probe_head(probe_head),
        .probe_apple(probe_apple),
        .seeding(seeding),
        .button_held(button_held),
        .eaten(eaten)
    );

    direction_latch u_dir (
        .clk(clk),
        .rst_n(rst_n),
        .in_left(in_left),
        .in_right(in_right),
        .in_up(in_up),
        .in_down(in_down),
        .current(current),
        .force_down(force_down),
        .next_dir(next_dir)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    body_fifo u_body (
        .clk(clk),
        .rst_n(rst_n),
        .load(body_load),
        .push(body_push),
        .pop(body_pop),
        .rd_req(body_rd_req),
        .push_cell(push_cell),
        .tail_next(tail_next)
    );

    occupancy_map u_map (
        .clk(clk),
        .rst_n(rst_n),
        .set(map_set),
        .clr(map_clr),
        .clear_all(map_clear),
        .set_cell(set_cell),
        .clr_cell(clr_cell),
        .probe_head(probe_head),
        .probe_apple(probe_apple),
        .body_hit(body_hit),
        .apple_hit(apple_hit)
    );

    apple_lfsr u_lfsr (
        .clk(clk),
        .rst_n(rst_n),
        .seeding(seeding),
        .any_button(button_held),
        .eaten(eaten),
        .rand_cell(rand_cell)
    );

endmodule
